//--- cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Byte address split: tag 15:8, index 7:3, offset 2:0
`define CACHE_TAG_W          8
`define CACHE_INDEX_W        5

`define CACHE_LINES          32
`define CACHE_WORDS_PER_LINE 4   // Offsets 0, 2, 4, 6

// Main memory
`define MEM_WORDS            32768 // Whole 64 KB byte space
`define MEM_READ_LAT         2     // Request to data, in cycles

`endif

//--- cache_pkg.sv
`default_nettype none
`include "cache_cfg.svh"

package cache_pkg;

	typedef enum logic [3:0] {
		st_idle          = 4'd0,
		st_evict0        = 4'd1,
		st_evict1        = 4'd2,
		st_evict2        = 4'd3,
		st_evict3        = 4'd4,
		st_fill_req0     = 4'd5,
		st_fill_req1     = 4'd6,
		st_fill_wr0      = 4'd7,  // Also issues read 2
		st_fill_wr1      = 4'd8,  // Also issues read 3
		st_fill_wr2      = 4'd9,
		st_fill_wr3      = 4'd10,
		st_compare_write = 4'd11
	} ctrl_state_e;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        rd;
		logic        wr;
	} cpu_req_t;

	typedef struct packed {
		logic        enable;
		logic        comp;     // Tag compare, else direct line access
		logic        write;
		logic        data_src; // 1 takes the memory word
		logic [2:0]  offset;
		logic [15:0] wdata;
	} cache_ctl_t;

	typedef struct packed {
		logic                    hit;
		logic                    valid;
		logic                    dirty;
		logic [`CACHE_TAG_W-1:0] tag;
		logic [15:0]             rdata;
	} cache_status_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        rd;
		logic        wr;
	} mem_req_t;

endpackage

`default_nettype wire

//--- cache_array.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_cfg.svh"

module cache_array (
	input  wire                        clk,
	input  wire                        rst,
	input  wire cache_pkg::cache_ctl_t ctl,
	input  wire [15:0]                 req_addr,
	input  wire [15:0]                 fill_data,
	output cache_pkg::cache_status_t   status
);

	localparam int OFS_W  = 3;
	localparam int WSEL_W = $clog2(`CACHE_WORDS_PER_LINE);
	localparam int NWORDS = `CACHE_LINES * `CACHE_WORDS_PER_LINE;
	localparam int WADR_W = `CACHE_INDEX_W + WSEL_W;

	logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_LINES];
	logic [15:0]             data_mem [NWORDS];
	logic [`CACHE_LINES-1:0] valid_q;
	logic [`CACHE_LINES-1:0] dirty_q;

	logic [`CACHE_TAG_W-1:0]   req_tag;
	logic [`CACHE_INDEX_W-1:0] idx;
	logic [WADR_W-1:0]         word_addr;
	logic                      tag_match;
	logic                      wr_en;
	logic [15:0]               wr_word;

	assign req_tag   = req_addr[15 -: `CACHE_TAG_W];
	assign idx       = req_addr[OFS_W +: `CACHE_INDEX_W];
	assign word_addr = {idx, ctl.offset[1 +: WSEL_W]}; // Byte offset bit 0 dropped

	assign tag_match = valid_q[idx] && (tag_mem[idx] == req_tag);

	// Compare writes only land on a hit, line access writes always do
	assign wr_en = ctl.enable & ctl.write & (~ctl.comp | tag_match);

	// Memory word forwarded by the controller, else CPU store data
	assign wr_word = ctl.data_src ? ctl.wdata : fill_data;

	always_comb begin
		status.hit   = tag_match;
		status.valid = valid_q[idx];
		status.dirty = dirty_q[idx];
		status.tag   = tag_mem[idx];     // Victim tag for eviction
		status.rdata = data_mem[word_addr];
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			data_mem[word_addr] <= wr_word;
			if (!ctl.comp) begin
				tag_mem[idx] <= req_tag; // Installing a new line
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (wr_en) begin
			if (ctl.comp) begin
				dirty_q[idx] <= 1'b1; // CPU store
			end else begin
				valid_q[idx] <= 1'b1;
				dirty_q[idx] <= 1'b0; // Fresh copy of memory
			end
		end
	end

endmodule

`default_nettype wire

//--- cache_controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_cfg.svh"

module cache_controller (
	input  wire                           clk,
	input  wire                           rst,
	input  wire cache_pkg::cpu_req_t      req,
	input  wire cache_pkg::cache_status_t status,
	input  wire [15:0]                    mem_rdata,
	output cache_pkg::cache_ctl_t         ctl,
	output cache_pkg::mem_req_t           mem_req,
	output logic                          done,
	output logic                          hit,
	output logic                          err
);

	import cache_pkg::*;

	localparam int OFS_W = 3;

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	logic [15:0] addr_q;
	logic        rd_q;
	logic        wr_q;
	logic        retry_q;

	logic                      access;
	logic                      misaligned;
	logic [`CACHE_TAG_W-1:0]   tag_q;
	logic [`CACHE_INDEX_W-1:0] idx_q;

	assign access     = req.rd | req.wr;
	assign misaligned = access & req.addr[0]; // Words sit on even bytes
	assign tag_q      = addr_q[15 -: `CACHE_TAG_W];
	assign idx_q      = addr_q[OFS_W +: `CACHE_INDEX_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	// Request captured every idle cycle, held through the miss
	always_ff @(posedge clk) begin
		if (state == st_idle) begin
			addr_q <= req.addr;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_q <= 1'b0;
			wr_q <= 1'b0;
		end else if (state == st_idle) begin
			rd_q <= req.rd;
			wr_q <= req.wr;
		end
	end

	// Marks the idle cycle that repeats a read lookup after its fill
	always_ff @(posedge clk) begin
		if (rst) begin
			retry_q <= 1'b0;
		end else begin
			retry_q <= (state == st_fill_wr3);
		end
	end

	always_comb begin
		state_nxt = state;
		ctl       = '0;
		ctl.wdata = mem_rdata; // Fill word, used when data_src is set
		mem_req   = '0;
		done      = 1'b0;
		hit       = 1'b0;
		err       = 1'b0;

		case (state)
			st_idle: begin
				if (misaligned) begin
					err  = 1'b1;
					done = 1'b1;
				end else if (access) begin
					ctl.enable = 1'b1;
					ctl.comp   = 1'b1;
					ctl.write  = req.wr;
					ctl.offset = req.addr[OFS_W-1:0];
					if (status.hit) begin
						done = 1'b1;
						hit  = ~retry_q; // A missed read reports no hit
					end else if (status.valid && status.dirty) begin
						state_nxt = st_evict0;
					end else begin
						state_nxt = st_fill_req0;
					end
				end
			end

			// Write back the victim, one word per cycle
			st_evict0: begin
				ctl.enable     = 1'b1;
				ctl.offset     = 3'd0;
				mem_req.wr     = 1'b1;
				mem_req.addr   = {status.tag, idx_q, 3'd0};
				mem_req.wdata  = status.rdata;
				state_nxt      = st_evict1;
			end
			st_evict1: begin
				ctl.enable     = 1'b1;
				ctl.offset     = 3'd2;
				mem_req.wr     = 1'b1;
				mem_req.addr   = {status.tag, idx_q, 3'd2};
				mem_req.wdata  = status.rdata;
				state_nxt      = st_evict2;
			end
			st_evict2: begin
				ctl.enable     = 1'b1;
				ctl.offset     = 3'd4;
				mem_req.wr     = 1'b1;
				mem_req.addr   = {status.tag, idx_q, 3'd4};
				mem_req.wdata  = status.rdata;
				state_nxt      = st_evict3;
			end
			st_evict3: begin
				ctl.enable     = 1'b1;
				ctl.offset     = 3'd6;
				mem_req.wr     = 1'b1;
				mem_req.addr   = {status.tag, idx_q, 3'd6};
				mem_req.wdata  = status.rdata;
				state_nxt      = st_fill_req0;
			end

			st_fill_req0: begin
				mem_req.rd   = 1'b1;
				mem_req.addr = {tag_q, idx_q, 3'd0};
				state_nxt    = st_fill_req1;
			end
			st_fill_req1: begin
				mem_req.rd   = 1'b1;
				mem_req.addr = {tag_q, idx_q, 3'd2};
				state_nxt    = st_fill_wr0;
			end

			// Word 0 arrives while word 2 is requested
			st_fill_wr0: begin
				mem_req.rd   = 1'b1;
				mem_req.addr = {tag_q, idx_q, 3'd4};
				ctl.enable   = 1'b1;
				ctl.write    = 1'b1;
				ctl.data_src = 1'b1;
				ctl.offset   = 3'd0;
				state_nxt    = st_fill_wr1;
			end
			st_fill_wr1: begin
				mem_req.rd   = 1'b1;
				mem_req.addr = {tag_q, idx_q, 3'd6};
				ctl.enable   = 1'b1;
				ctl.write    = 1'b1;
				ctl.data_src = 1'b1;
				ctl.offset   = 3'd2;
				state_nxt    = st_fill_wr2;
			end
			st_fill_wr2: begin
				ctl.enable   = 1'b1;
				ctl.write    = 1'b1;
				ctl.data_src = 1'b1;
				ctl.offset   = 3'd4;
				state_nxt    = st_fill_wr3;
			end
			st_fill_wr3: begin
				ctl.enable   = 1'b1;
				ctl.write    = 1'b1;
				ctl.data_src = 1'b1;
				ctl.offset   = 3'd6;
				// Reads retry the lookup in idle, writes still owe the store
				state_nxt    = (wr_q && !rd_q) ? st_compare_write : st_idle;
			end

			st_compare_write: begin
				ctl.enable = 1'b1;
				ctl.comp   = 1'b1;
				ctl.write  = 1'b1;
				ctl.offset = addr_q[OFS_W-1:0];
				done       = 1'b1;
				state_nxt  = st_idle;
			end

			default: begin
				err       = 1'b1; // Unused encoding
				state_nxt = st_idle;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- bank_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cache_cfg.svh"

module bank_memory (
	input  wire                       clk,
	input  wire cache_pkg::mem_req_t  mem_req,
	output logic [15:0]               rdata,
	output logic                      rvalid
);

	localparam int BANKS = `CACHE_WORDS_PER_LINE; // One bank per word of a line
	localparam int ROWS  = `MEM_WORDS / BANKS;
	localparam int SEL_W = $clog2(BANKS);
	localparam int ROW_W = $clog2(ROWS);
	localparam int LAT   = `MEM_READ_LAT;

	logic [15:0] bank [BANKS][ROWS];

	logic [SEL_W-1:0] sel;
	logic [ROW_W-1:0] row;

	// Read pipeline, stage 0 holds the bank output
	logic [15:0]    pipe_data [LAT];
	logic [LAT-1:0] pipe_valid = '0;

	assign sel = mem_req.addr[1 +: SEL_W];
	assign row = mem_req.addr[1 + SEL_W +: ROW_W];

	// Every word starts out holding its own byte address
	initial begin
		for (int b = 0; b < BANKS; b++) begin
			for (int r = 0; r < ROWS; r++) begin
				bank[b][r] = 16'((r * BANKS + b) * 2);
			end
		end
	end

	always @(posedge clk) begin
		if (mem_req.wr) begin
			bank[sel][row] <= mem_req.wdata;
		end
	end

	always_ff @(posedge clk) begin
		pipe_valid[0] <= mem_req.rd;
		if (mem_req.rd) begin
			pipe_data[0] <= bank[sel][row];
		end
		for (int s = 1; s < LAT; s++) begin
			pipe_valid[s] <= pipe_valid[s-1];
			pipe_data[s]  <= pipe_data[s-1];
		end
	end

	assign rdata  = pipe_data[LAT-1];
	assign rvalid = pipe_valid[LAT-1];

endmodule

`default_nettype wire

//--- mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module mem_system (
	input  wire                      clk,
	input  wire                      rst,
	input  wire cache_pkg::cpu_req_t req,
	output logic [15:0]              data_out,
	output logic                     done,
	output logic                     hit,
	output logic                     err
);

	import cache_pkg::*;

	cache_ctl_t    ctl;
	cache_status_t status;
	mem_req_t      mem_req;
	logic [15:0]   mem_rdata;

	// Lookup runs on the live address, held stable until done
	cache_array i_array (
		.clk       (clk),
		.rst       (rst),
		.ctl       (ctl),
		.req_addr  (req.addr),
		.fill_data (req.wdata),
		.status    (status)
	);

	cache_controller i_ctrl (
		.clk       (clk),
		.rst       (rst),
		.req       (req),
		.status    (status),
		.mem_rdata (mem_rdata),
		.ctl       (ctl),
		.mem_req   (mem_req),
		.done      (done),
		.hit       (hit),
		.err       (err)
	);

	bank_memory i_mem (
		.clk     (clk),
		.mem_req (mem_req),
		.rdata   (mem_rdata),
		.rvalid  ()             // Fixed latency, controller counts cycles
	);

	assign data_out = status.rdata;

endmodule

`default_nettype wire

//--- tb_mem_system.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_system;

	import cache_pkg::*;

	localparam int DONE_TIMEOUT = 50; // Cycles allowed per access
	localparam int MISS_CYCLES  = 7;  // Clean miss, fill only
	localparam int EVICT_CYCLES = 11; // Dirty miss, write back then fill

	logic        clk;
	logic        rst;
	cpu_req_t    req;
	logic [15:0] data_out;
	logic        done;
	logic        hit;
	logic        err;

	int fd;
	int n_access;

	mem_system i_dut (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.data_out (data_out),
		.done     (done),
		.hit      (hit),
		.err      (err)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic compare_data(input int idx, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH data_out access %0d: expected 0x%h, got 0x%h",
				idx, exp, got));
		end
	endtask

	task automatic compare_hit(input int idx, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH hit access %0d: expected 0x%h, got 0x%h",
				idx, exp, got));
		end
	endtask

	task automatic compare_err(input int idx, input logic got, input logic exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("MISMATCH err access %0d: expected 0x%h, got 0x%h",
				idx, exp, got));
		end
	endtask

	// A hit or an error finishes at once, a miss takes the fill or evict path
	task automatic check_latency(input int idx, input logic quick, input int cycles);
		logic ok;
		if (quick) begin
			ok = (cycles == 0);
		end else begin
			ok = (cycles == MISS_CYCLES) || (cycles == EVICT_CYCLES);
		end
		if (!ok) begin
			stop_with_failure($sformatf("access %0d finished after %0d cycles, %s",
				idx, cycles, "which fits neither a hit nor a miss"));
		end
	endtask

	task automatic run_access(input int idx, input logic is_wr, input logic [15:0] addr,
			input logic [15:0] wdata, output logic got_hit, output logic got_err,
			output logic [15:0] got_data, output int cycles);
		int gap;
		gap = $urandom_range(3, 0);
		@(posedge clk);
		if (gap > 0) begin
			req.rd <= 1'b0; // Idle gap between accesses
			req.wr <= 1'b0;
			repeat (gap) @(posedge clk);
		end
		req.addr  <= addr;
		req.wdata <= wdata;
		req.rd    <= ~is_wr;
		req.wr    <= is_wr;
		cycles = 0;
		@(negedge clk);
		while (!done && cycles < DONE_TIMEOUT) begin
			cycles++;
			@(negedge clk);
		end
		if (done) begin
			got_hit  = hit;
			got_err  = err;
			got_data = data_out;
		end else begin
			stop_with_failure($sformatf("access %0d got no done within %0d cycles",
				idx, DONE_TIMEOUT));
		end
	endtask

	initial begin
		string       line;
		int          fields;
		int          line_no;
		int          cycles;
		logic        is_comment;
		logic [3:0]  op;
		logic [3:0]  exp_hit;
		logic [3:0]  exp_err;
		logic [15:0] addr;
		logic [15:0] wdata;
		logic [15:0] exp_data;
		logic        got_hit;
		logic        got_err;
		logic [15:0] got_data;

		rst       = 1'b1;
		req       = '0;
		n_access  = 0;
		line_no   = 0;
		void'($urandom(38));

		fd = $fopen("mem_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_failure("cannot open the stimulus file mem_stimulus.txt");
		end else begin
			repeat (8) @(posedge clk);
			rst <= 1'b0;

			while (!$feof(fd)) begin
				line = "";
				fields = $fgets(line, fd);
				line_no++;
				is_comment = (line.len() == 0) || (line[0] == "#") || (line[0] == "\n");
				if (!is_comment) begin
					fields = $sscanf(line, "%h %h %h %h %h %h",
						op, addr, wdata, exp_data, exp_hit, exp_err);
					if (fields != 6) begin
						stop_with_failure($sformatf("stimulus line %0d cannot be parsed",
							line_no));
					end else begin
						run_access(n_access, op[0], addr, wdata,
							got_hit, got_err, got_data, cycles);
						compare_err(n_access, got_err, exp_err[0]);
						compare_hit(n_access, got_hit, exp_hit[0]);
						check_latency(n_access, exp_hit[0] | exp_err[0], cycles);
						if (!op[0] && !exp_err[0]) begin
							compare_data(n_access, got_data, exp_data); // Reads only
						end
						n_access++;
					end
				end
			end
			$fclose(fd);

			if (n_access == 0) begin
				stop_with_failure("the stimulus file holds no accesses");
			end else begin
				$display("%0d accesses checked", n_access);
				$display("** PASS **");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

//--- mem_stimulus.txt
# op addr wdata exp_data exp_hit exp_err, all fields hex
# op 0 reads and 1 writes, exp_data is ignored for writes and for errors
0 1230 0000 1230 0 0
0 1230 0000 1230 1 0
0 1232 0000 1232 1 0
0 1234 0000 1234 1 0
0 1236 0000 1236 1 0
1 1232 abcd 0000 1 0
0 1232 0000 abcd 1 0
0 3430 0000 3430 0 0
0 1232 0000 abcd 0 0
0 1230 0000 1230 1 0
1 1236 5a5a 0000 1 0
0 3436 0000 3436 0 0
0 1236 0000 5a5a 0 0
0 1232 0000 abcd 1 0
1 5678 1111 0000 0 0
0 5678 0000 1111 1 0
0 567a 0000 567a 1 0
0 567c 0000 567c 1 0
0 567e 0000 567e 1 0
1 9978 2222 0000 0 0
0 9978 0000 2222 1 0
0 5678 0000 1111 0 0
1 5679 ffff 0000 0 1
0 1231 0000 0000 0 1
0 5678 0000 1111 1 0
0 9978 0000 2222 0 0
0 fffe 0000 fffe 0 0
0 0000 0000 0000 0 0
0 1230 0000 1230 1 0

//--- sim.f
+incdir+.
cache_pkg.sv
cache_array.sv
cache_controller.sv
bank_memory.sv
mem_system.sv
tb_mem_system.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_mem_system
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
STIMULUS  := mem_stimulus.txt
SOURCES   := cache_cfg.svh cache_pkg.sv cache_array.sv cache_controller.sv \
             bank_memory.sv mem_system.sv tb_mem_system.sv

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(STIMULUS)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
